//--- hdl/tlk2711_tx.sv
`timescale 1ns/1ps

module tlk2711_tx (
    input  logic                    clk,
    input  logic                    i_soft_reset,
    input  logic                    i_tx_start,
    input  tlk_tx_pkg::tx_mode_t    i_tx_mode,
    input  tlk_tx_pkg::tx_cfg_t     i_tx_cfg,
    input  logic                    i_loopback_ena,
    input  logic                    i_tx_pre,
    input  logic                    i_dma_rd_valid,
    input  tlk_tx_pkg::dma_beat_t   i_dma_rd_data,
    output logic                    o_dma_rd_ready,
    output logic                    o_tx_interrupt,
    output tlk_tx_pkg::tx_status_t  o_tx_status,
    output logic                    o_2711_tkmsb,
    output logic                    o_2711_tklsb,
    output tlk_tx_pkg::tx_word_t    o_2711_txd,
    output logic                    o_2711_enable,
    output logic                    o_2711_lckrefn,
    output logic                    o_2711_loopen,
    output logic                    o_2711_pre
);

    logic                   fifo_wr_en;
    logic                   fifo_full;
    logic                   fifo_empty;
    tlk_tx_pkg::tx_word_t   fifo_word;
    logic                   word_pop;
    logic                   dma_enable;
    tlk_tx_pkg::line_word_t line;
    tlk_tx_pkg::tx_state_t  state;
    tlk_tx_pkg::tx_mode_t   mode;
    logic                   pin_on;

    // serdes enable and lckrefn come up one cycle after reset
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            pin_on <= 1'b0;
        end else begin
            pin_on <= 1'b1;
        end
    end

    assign o_2711_enable  = pin_on;
    assign o_2711_lckrefn = pin_on;
    assign o_2711_loopen  = i_loopback_ena;
    assign o_2711_pre     = i_tx_pre;

    assign o_dma_rd_ready = ~fifo_full;
    assign fifo_wr_en     = i_dma_rd_valid & o_dma_rd_ready & dma_enable;

    tx_word_fifo u_tx_word_fifo (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_wr_en      (fifo_wr_en),
        .i_wr_data    (i_dma_rd_data),
        .i_rd_en      (word_pop),
        .o_rd_data    (fifo_word),
        .o_full       (fifo_full),
        .o_empty      (fifo_empty)
    );

    tx_frame_fsm u_tx_frame_fsm (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_tx_start     (i_tx_start),
        .i_tx_mode      (i_tx_mode),
        .i_tx_cfg       (i_tx_cfg),
        .i_fifo_empty   (fifo_empty),
        .i_fifo_word    (fifo_word),
        .o_word_pop     (word_pop),
        .o_dma_enable   (dma_enable),
        .o_line         (line),
        .o_tx_interrupt (o_tx_interrupt),
        .o_state        (state),
        .o_mode         (mode)
    );

    tx_line_stage u_tx_line_stage (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_line       (line),
        .o_tkmsb      (o_2711_tkmsb),
        .o_tklsb      (o_2711_tklsb),
        .o_txd        (o_2711_txd)
    );

    assign o_tx_status = '{
        fifo_empty: fifo_empty,
        fifo_full:  fifo_full,
        state:      state,
        mode:       mode
    };

endmodule

//--- hdl/tlk_tx_defines.svh
`ifndef TLK_TX_DEFINES_SVH
`define TLK_TX_DEFINES_SVH

//////////////////////////////
// 8b/10b code bytes
//////////////////////////////

// comma pair
`define TLK_K28_5 8'hBC
`define TLK_D5_6 8'hC5

// start of frame
`define TLK_K27_7 8'hFB
`define TLK_K28_2 8'h5C

// end of frame
`define TLK_K30_7 8'hFE
`define TLK_K29_7 8'hFD

//////////////////////////////
// frame fields
//////////////////////////////

`define TLK_HEAD_0 16'hEB90
`define TLK_HEAD_1 16'hE116
`define TLK_TX_IND 8'h81
`define TLK_FILE_END 8'h01

// comma words before frame 0 and after every eof
`define TLK_SYNC_CYCLES 6
`define TLK_BACKWARD_CYCLES 257

`define TLK_FIFO_BEATS 32

`endif

//--- hdl/tlk_tx_pkg.sv
package tlk_tx_pkg;

    typedef logic [63:0] dma_beat_t;
    typedef logic [15:0] tx_word_t;
    typedef logic [15:0] byte_len_t;
    typedef logic [23:0] frame_num_t;
    typedef logic [15:0] intr_width_t;

    // values 2..7 keep the framer idle
    typedef enum logic [2:0] {
        TX_MODE_NORM  = 3'd0,
        TX_MODE_KCODE = 3'd1
    } tx_mode_t;

    typedef enum logic [3:0] {
        TX_IDLE,
        TX_BEGIN,
        TX_SYNC,
        TX_SOF,
        TX_HEAD,
        TX_FILE_SIGN,
        TX_FRAME_NUM,
        TX_VLD_LEN,
        TX_VLD_DATA,
        TX_CHECKSUM,
        TX_EOF,
        TX_BACKWARD,
        TX_INTERRUPT
    } tx_state_t;

    // body_num is the index of the last frame
    typedef struct packed {
        byte_len_t   body_len;
        byte_len_t   tail_len;
        frame_num_t  body_num;
        intr_width_t intr_width;
    } tx_cfg_t;

    typedef struct packed {
        logic     k_msb;
        logic     k_lsb;
        tx_word_t data;
        logic     sum_add;
        logic     sum_insert;
    } line_word_t;

    typedef struct packed {
        logic      fifo_empty;
        logic      fifo_full;
        tx_state_t state;
        tx_mode_t  mode;
    } tx_status_t;

endpackage

//--- hdl/tx_frame_fsm.sv
`timescale 1ns/1ps
`include "tlk_tx_defines.svh"

module tx_frame_fsm (
    input  logic                   clk,
    input  logic                   i_soft_reset,
    input  logic                   i_tx_start,
    input  tlk_tx_pkg::tx_mode_t   i_tx_mode,
    input  tlk_tx_pkg::tx_cfg_t    i_tx_cfg,
    input  logic                   i_fifo_empty,
    input  tlk_tx_pkg::tx_word_t   i_fifo_word,
    output logic                   o_word_pop,
    output logic                   o_dma_enable,
    output tlk_tx_pkg::line_word_t o_line,
    output logic                   o_tx_interrupt,
    output tlk_tx_pkg::tx_state_t  o_state,
    output tlk_tx_pkg::tx_mode_t   o_mode
);

    localparam int SYNC_W = $clog2(`TLK_SYNC_CYCLES);
    localparam int BACK_W = $clog2(`TLK_BACKWARD_CYCLES);

    tlk_tx_pkg::tx_state_t   state_q;
    tlk_tx_pkg::tx_state_t   state_d;
    tlk_tx_pkg::tx_mode_t    mode_q;
    tlk_tx_pkg::tx_cfg_t     cfg_q;
    logic                    cfg_pending;
    logic [SYNC_W-1:0]       sync_cnt;
    logic                    head_cnt;
    logic [14:0]             data_cnt;
    logic [BACK_W-1:0]       back_cnt;
    tlk_tx_pkg::intr_width_t intr_cnt;
    tlk_tx_pkg::frame_num_t  frame_cnt;
    logic                    last_frame;
    tlk_tx_pkg::byte_len_t   cur_len;
    logic [14:0]             data_words;

    //////////////////////////////
    // start pulse latches
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_tx_start) begin
            cfg_q <= i_tx_cfg;
        end
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            mode_q       <= tlk_tx_pkg::TX_MODE_NORM;
            cfg_pending  <= 1'b0;
            o_dma_enable <= 1'b0;
        end else begin
            if (i_tx_start) begin
                mode_q <= i_tx_mode;
            end
            if (i_tx_start) begin
                cfg_pending <= 1'b1;
            end else if (state_q == tlk_tx_pkg::TX_BEGIN) begin
                cfg_pending <= 1'b0;
            end
            // stays on until the next soft reset
            if (i_tx_start && i_tx_mode == tlk_tx_pkg::TX_MODE_NORM) begin
                o_dma_enable <= 1'b1;
            end
        end
    end

    assign last_frame = (frame_cnt == cfg_q.body_num);
    assign cur_len    = last_frame ? cfg_q.tail_len : cfg_q.body_len;
    assign data_words = cur_len[15:1];

    //////////////////////////////
    // sequencer
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            tlk_tx_pkg::TX_IDLE: begin
                if (cfg_pending && !i_fifo_empty) begin
                    state_d = tlk_tx_pkg::TX_BEGIN;
                end
            end
            tlk_tx_pkg::TX_BEGIN: state_d = tlk_tx_pkg::TX_SYNC;
            tlk_tx_pkg::TX_SYNC: begin
                if (sync_cnt == SYNC_W'(`TLK_SYNC_CYCLES - 1)) begin
                    state_d = tlk_tx_pkg::TX_SOF;
                end
            end
            tlk_tx_pkg::TX_SOF: state_d = tlk_tx_pkg::TX_HEAD;
            tlk_tx_pkg::TX_HEAD: begin
                if (head_cnt) begin
                    state_d = tlk_tx_pkg::TX_FILE_SIGN;
                end
            end
            tlk_tx_pkg::TX_FILE_SIGN: state_d = tlk_tx_pkg::TX_FRAME_NUM;
            tlk_tx_pkg::TX_FRAME_NUM: state_d = tlk_tx_pkg::TX_VLD_LEN;
            tlk_tx_pkg::TX_VLD_LEN: begin
                // a length below two bytes carries no data words
                state_d = (data_words == '0) ? tlk_tx_pkg::TX_CHECKSUM : tlk_tx_pkg::TX_VLD_DATA;
            end
            tlk_tx_pkg::TX_VLD_DATA: begin
                if (data_cnt == data_words - 1'b1) begin
                    state_d = tlk_tx_pkg::TX_CHECKSUM;
                end
            end
            tlk_tx_pkg::TX_CHECKSUM: state_d = tlk_tx_pkg::TX_EOF;
            tlk_tx_pkg::TX_EOF: state_d = tlk_tx_pkg::TX_BACKWARD;
            tlk_tx_pkg::TX_BACKWARD: begin
                if (back_cnt == BACK_W'(`TLK_BACKWARD_CYCLES - 1)) begin
                    state_d = last_frame ? tlk_tx_pkg::TX_INTERRUPT : tlk_tx_pkg::TX_SOF;
                end
            end
            tlk_tx_pkg::TX_INTERRUPT: begin
                if (intr_cnt == cfg_q.intr_width - 1'b1) begin
                    state_d = tlk_tx_pkg::TX_IDLE;
                end
            end
            default: state_d = tlk_tx_pkg::TX_IDLE;
        endcase
        // k-code and unknown modes never run frames
        if (mode_q != tlk_tx_pkg::TX_MODE_NORM) begin
            state_d = tlk_tx_pkg::TX_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state_q   <= tlk_tx_pkg::TX_IDLE;
            sync_cnt  <= '0;
            head_cnt  <= 1'b0;
            data_cnt  <= '0;
            back_cnt  <= '0;
            intr_cnt  <= '0;
            frame_cnt <= '0;
        end else begin
            state_q  <= state_d;
            // each counter runs only inside its own state
            sync_cnt <= (state_q == tlk_tx_pkg::TX_SYNC) ? sync_cnt + 1'b1 : '0;
            head_cnt <= (state_q == tlk_tx_pkg::TX_HEAD) ? ~head_cnt : 1'b0;
            data_cnt <= (state_q == tlk_tx_pkg::TX_VLD_DATA) ? data_cnt + 1'b1 : '0;
            back_cnt <= (state_q == tlk_tx_pkg::TX_BACKWARD) ? back_cnt + 1'b1 : '0;
            intr_cnt <= (state_q == tlk_tx_pkg::TX_INTERRUPT) ? intr_cnt + 1'b1 : '0;
            // frame index held through the gap, so last_frame stays valid there
            if (state_q == tlk_tx_pkg::TX_BEGIN) begin
                frame_cnt <= '0;
            end else if (state_q == tlk_tx_pkg::TX_BACKWARD && state_d == tlk_tx_pkg::TX_SOF) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////
    // line word
    //////////////////////////////

    always_comb begin
        // comma by default
        o_line.k_msb      = 1'b0;
        o_line.k_lsb      = 1'b1;
        o_line.data       = {`TLK_D5_6, `TLK_K28_5};
        o_line.sum_add    = 1'b0;
        o_line.sum_insert = 1'b0;
        if (mode_q == tlk_tx_pkg::TX_MODE_KCODE) begin
            o_line.k_msb = 1'b1;
            o_line.data  = {`TLK_K28_2, `TLK_K27_7};
        end else begin
            case (state_q)
                tlk_tx_pkg::TX_SOF: begin
                    o_line.k_msb = 1'b1;
                    o_line.data  = {`TLK_K28_2, `TLK_K27_7};
                end
                tlk_tx_pkg::TX_HEAD: begin
                    o_line.k_lsb = 1'b0;
                    o_line.data  = head_cnt ? `TLK_HEAD_1 : `TLK_HEAD_0;
                end
                tlk_tx_pkg::TX_FILE_SIGN: begin
                    o_line.k_lsb = 1'b0;
                    o_line.data  = {`TLK_TX_IND, last_frame ? `TLK_FILE_END : 8'h00};
                end
                tlk_tx_pkg::TX_FRAME_NUM: begin
                    o_line.k_lsb   = 1'b0;
                    o_line.data    = frame_cnt[15:0];
                    o_line.sum_add = 1'b1;
                end
                tlk_tx_pkg::TX_VLD_LEN: begin
                    o_line.k_lsb   = 1'b0;
                    o_line.data    = cur_len;
                    o_line.sum_add = 1'b1;
                end
                tlk_tx_pkg::TX_VLD_DATA: begin
                    o_line.k_lsb   = 1'b0;
                    o_line.data    = i_fifo_word;
                    o_line.sum_add = 1'b1;
                end
                tlk_tx_pkg::TX_CHECKSUM: begin
                    // line stage puts the sum in this slot
                    o_line.k_lsb      = 1'b0;
                    o_line.data       = '0;
                    o_line.sum_insert = 1'b1;
                end
                tlk_tx_pkg::TX_EOF: begin
                    o_line.k_msb = 1'b1;
                    o_line.data  = {`TLK_K29_7, `TLK_K30_7};
                end
                default: begin
                    o_line.k_lsb = 1'b1;
                end
            endcase
        end
    end

    assign o_word_pop     = (state_q == tlk_tx_pkg::TX_VLD_DATA);
    assign o_tx_interrupt = (state_q == tlk_tx_pkg::TX_INTERRUPT);
    assign o_state        = state_q;
    assign o_mode         = mode_q;

endmodule

//--- hdl/tx_line_stage.sv
`timescale 1ns/1ps

module tx_line_stage (
    input  logic                   clk,
    input  logic                   i_soft_reset,
    input  tlk_tx_pkg::line_word_t i_line,
    output logic                   o_tkmsb,
    output logic                   o_tklsb,
    output tlk_tx_pkg::tx_word_t   o_txd
);

    tlk_tx_pkg::tx_word_t checksum;

    //////////////////////////////
    // checksum, modulo 2^16
    //////////////////////////////

    // covers frame number, length and data words
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            checksum <= '0;
        end else if (i_line.sum_insert) begin
            // restart for the next frame
            checksum <= '0;
        end else if (i_line.sum_add) begin
            checksum <= checksum + i_line.data;
        end
    end

    //////////////////////////////
    // pin register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_tkmsb <= 1'b0;
            o_tklsb <= 1'b0;
            o_txd   <= '0;
        end else begin
            o_tkmsb <= i_line.k_msb;
            o_tklsb <= i_line.k_lsb;
            // sum is complete here, the last add was the cycle before
            o_txd   <= i_line.sum_insert ? checksum : i_line.data;
        end
    end

endmodule

//--- hdl/tx_word_fifo.sv
`timescale 1ns/1ps
`include "tlk_tx_defines.svh"

module tx_word_fifo (
    input  logic                 clk,
    input  logic                 i_soft_reset,
    input  logic                 i_wr_en,
    input  tlk_tx_pkg::dma_beat_t i_wr_data,
    input  logic                 i_rd_en,
    output tlk_tx_pkg::tx_word_t  o_rd_data,
    output logic                 o_full,
    output logic                 o_empty
);

    localparam int DEPTH = `TLK_FIFO_BEATS;
    localparam int AW = $clog2(DEPTH);

    tlk_tx_pkg::dma_beat_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   beat_cnt;
    logic [1:0]    word_sel;
    logic          beat_done;

    //////////////////////////////
    // write side
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    //////////////////////////////
    // read side, fall-through
    //////////////////////////////

    // low half-word of a beat goes out first
    assign o_rd_data = mem[rd_ptr][word_sel*16 +: 16];

    // beat slot freed on its fourth word
    assign beat_done = i_rd_en && !o_empty && (word_sel == 2'd3);

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            word_sel <= '0;
            beat_cnt <= '0;
        end else begin
            if (i_wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_rd_en && !o_empty) begin
                word_sel <= word_sel + 1'b1;
            end
            if (beat_done) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (i_wr_en && !beat_done) begin
                beat_cnt <= beat_cnt + 1'b1;
            end else if (beat_done && !i_wr_en) begin
                beat_cnt <= beat_cnt - 1'b1;
            end
        end
    end

    assign o_empty = (beat_cnt == '0);
    assign o_full  = (beat_cnt == (AW+1)'(DEPTH));

endmodule

//--- tests/tlk2711_tx_tb.sv
`timescale 1ns/1ps
`include "tlk_tx_defines.svh"

module tlk2711_tx_tb;

    localparam logic [15:0] COMMA_WORD = {`TLK_D5_6, `TLK_K28_5};
    localparam logic [15:0] SOF_WORD   = {`TLK_K28_2, `TLK_K27_7};
    localparam logic [15:0] EOF_WORD   = {`TLK_K29_7, `TLK_K30_7};

    logic                   clk = 1'b0;
    logic                   i_soft_reset;
    logic                   i_tx_start;
    tlk_tx_pkg::tx_mode_t   i_tx_mode;
    tlk_tx_pkg::tx_cfg_t    i_tx_cfg;
    logic                   i_loopback_ena;
    logic                   i_tx_pre;
    logic                   i_dma_rd_valid;
    tlk_tx_pkg::dma_beat_t  i_dma_rd_data;
    logic                   o_dma_rd_ready;
    logic                   o_tx_interrupt;
    tlk_tx_pkg::tx_status_t o_tx_status;
    logic                   o_2711_tkmsb;
    logic                   o_2711_tklsb;
    tlk_tx_pkg::tx_word_t   o_2711_txd;
    logic                   o_2711_enable;
    logic                   o_2711_lckrefn;
    logic                   o_2711_loopen;
    logic                   o_2711_pre;

    integer                 seed;
    tlk_tx_pkg::dma_beat_t  beats [3];
    logic [15:0]            exp_words [$];
    tlk_tx_pkg::tx_cfg_t    run_cfg;
    logic                   w_kmsb;
    logic                   w_klsb;
    logic [15:0]            w_data;
    logic                   intr_prev = 1'b0;
    int                     intr_pulses = 0;
    int                     cnt;
    int                     accepted;

    always #2 clk = ~clk;

    tlk2711_tx u_tlk2711_tx (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_tx_start     (i_tx_start),
        .i_tx_mode      (i_tx_mode),
        .i_tx_cfg       (i_tx_cfg),
        .i_loopback_ena (i_loopback_ena),
        .i_tx_pre       (i_tx_pre),
        .i_dma_rd_valid (i_dma_rd_valid),
        .i_dma_rd_data  (i_dma_rd_data),
        .o_dma_rd_ready (o_dma_rd_ready),
        .o_tx_interrupt (o_tx_interrupt),
        .o_tx_status    (o_tx_status),
        .o_2711_tkmsb   (o_2711_tkmsb),
        .o_2711_tklsb   (o_2711_tklsb),
        .o_2711_txd     (o_2711_txd),
        .o_2711_enable  (o_2711_enable),
        .o_2711_lckrefn (o_2711_lckrefn),
        .o_2711_loopen  (o_2711_loopen),
        .o_2711_pre     (o_2711_pre)
    );

    //////////////////////////////
    // checking helpers
    //////////////////////////////

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t ns %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // pins are sampled mid-cycle, away from the clock edge
    task automatic sample_word();
        @(negedge clk);
        w_kmsb = o_2711_tkmsb;
        w_klsb = o_2711_tklsb;
        w_data = o_2711_txd;
    endtask

    task automatic check_line_word(input string what, input logic kmsb, input logic klsb,
                                   input logic [15:0] data);
        check_value({"o_2711_tkmsb at ", what}, w_kmsb, kmsb);
        check_value({"o_2711_tklsb at ", what}, w_klsb, klsb);
        check_value({"o_2711_txd at ", what}, w_data, data);
    endtask

    // leaves the first non-comma word in w_*
    task automatic count_commas(input int limit, output int count);
        count = 0;
        sample_word();
        while (w_kmsb === 1'b0 && w_klsb === 1'b1 && w_data === COMMA_WORD) begin
            count++;
            if (count > limit) begin
                $display("timeout: more than %0d comma words and no frame started", limit);
                stop_with_failure();
            end
            sample_word();
        end
    endtask

    task automatic push_beat(input tlk_tx_pkg::dma_beat_t beat);
        int waited;
        waited = 0;
        i_dma_rd_valid <= 1'b1;
        i_dma_rd_data  <= beat;
        @(negedge clk);
        while (o_dma_rd_ready !== 1'b1) begin
            waited++;
            if (waited > 100) begin
                $display("timeout: dma port never became ready");
                stop_with_failure();
            end
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // expects the sof word already sampled
    task automatic check_frame(input int n, input bit last, input int len);
        logic [15:0] sum;
        logic [15:0] exp;
        sum = n[15:0] + len[15:0];
        check_line_word("sof", 1'b1, 1'b1, SOF_WORD);
        sample_word();
        check_line_word("head 0", 1'b0, 1'b0, `TLK_HEAD_0);
        sample_word();
        check_line_word("head 1", 1'b0, 1'b0, `TLK_HEAD_1);
        sample_word();
        check_line_word("file sign", 1'b0, 1'b0,
                        {`TLK_TX_IND, (last ? `TLK_FILE_END : 8'h00)});
        sample_word();
        check_line_word("frame number", 1'b0, 1'b0, n[15:0]);
        sample_word();
        check_line_word("length", 1'b0, 1'b0, len[15:0]);
        for (int i = 0; i < len / 2; i++) begin
            sample_word();
            if (exp_words.size() == 0) begin
                $display("frame %0d wants more data words than were loaded", n);
                stop_with_failure();
            end
            exp = exp_words.pop_front();
            sum = sum + exp;
            check_line_word("data", 1'b0, 1'b0, exp);
        end
        sample_word();
        check_line_word("checksum", 1'b0, 1'b0, sum);
        sample_word();
        check_line_word("eof", 1'b1, 1'b1, EOF_WORD);
        check_value("o_tx_interrupt pulses before last eof", intr_pulses, 0);
    endtask

    //////////////////////////////
    // monitor
    //////////////////////////////

    always @(negedge clk) begin
        assert (!(o_tx_status.fifo_full === 1'b1 && o_dma_rd_ready === 1'b1)) else begin
            $display("ERROR %0t ns o_dma_rd_ready got 1 expected 0 with fifo full", $time);
            stop_with_failure();
        end
        if (o_tx_interrupt === 1'b1 && intr_prev !== 1'b1) begin
            intr_pulses++;
        end
        intr_prev = o_tx_interrupt;
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        i_soft_reset   = 1'b1;
        i_tx_start     = 1'b0;
        i_tx_mode      = tlk_tx_pkg::TX_MODE_NORM;
        i_tx_cfg       = '0;
        i_loopback_ena = 1'b1;
        i_tx_pre       = 1'b0;
        i_dma_rd_valid = 1'b0;
        i_dma_rd_data  = '0;
        seed           = 32'h52a0;
        run_cfg.body_len   = 16'd8;
        run_cfg.tail_len   = 16'd4;
        run_cfg.body_num   = 24'd2;
        run_cfg.intr_width = 16'd5;
        for (int b = 0; b < 3; b++) begin
            beats[b] = {$random(seed), $random(seed)};
            for (int w = 0; w < 4; w++) begin
                exp_words.push_back(beats[b][w*16 +: 16]);
            end
        end

        repeat (2) @(posedge clk);
        i_soft_reset <= 1'b0;
        @(negedge clk);
        check_value("o_tx_interrupt", o_tx_interrupt, 0);
        check_value("o_2711_tkmsb", o_2711_tkmsb, 0);
        check_value("o_2711_tklsb", o_2711_tklsb, 0);
        check_value("o_2711_txd", o_2711_txd, 0);
        check_value("o_2711_enable", o_2711_enable, 0);
        check_value("o_2711_lckrefn", o_2711_lckrefn, 0);
        check_value("o_2711_loopen", o_2711_loopen, 1);
        check_value("o_2711_pre", o_2711_pre, 0);
        check_value("o_tx_status.fifo_empty", o_tx_status.fifo_empty, 1);
        @(posedge clk);
        i_loopback_ena <= 1'b0;
        i_tx_pre       <= 1'b1;
        @(negedge clk);
        check_value("o_2711_enable", o_2711_enable, 1);
        check_value("o_2711_lckrefn", o_2711_lckrefn, 1);
        check_value("o_2711_loopen", o_2711_loopen, 0);
        check_value("o_2711_pre", o_2711_pre, 1);

        // normal mode, three frames
        @(posedge clk);
        i_tx_cfg   <= run_cfg;
        i_tx_start <= 1'b1;
        @(posedge clk);
        i_tx_start <= 1'b0;
        fork
            begin
                for (int b = 0; b < 3; b++) begin
                    push_beat(beats[b]);
                end
                i_dma_rd_valid <= 1'b0;
            end
            begin
                count_commas(64, cnt);
                assert (cnt >= `TLK_SYNC_CYCLES) else begin
                    $display("ERROR %0t ns sync commas got %0d expected at least %0d",
                             $time, cnt, `TLK_SYNC_CYCLES);
                    stop_with_failure();
                end
                for (int n = 0; n <= 2; n++) begin
                    check_frame(n, n == 2, (n == 2) ? 4 : 8);
                    if (n < 2) begin
                        count_commas(`TLK_BACKWARD_CYCLES + 16, cnt);
                        check_value("comma gap between frames", cnt, `TLK_BACKWARD_CYCLES);
                    end
                end
            end
        join
        // the short last frame reads only half of the third beat
        check_value("words left in expected queue", exp_words.size(), 2);

        // interrupt pulse width
        cnt = 0;
        while (o_tx_interrupt !== 1'b1) begin
            @(negedge clk);
            cnt++;
            if (cnt > 2 * `TLK_BACKWARD_CYCLES) begin
                $display("timeout: no interrupt after the last frame");
                stop_with_failure();
            end
        end
        cnt = 0;
        while (o_tx_interrupt === 1'b1) begin
            cnt++;
            if (cnt > 64) begin
                $display("timeout: interrupt stuck high");
                stop_with_failure();
            end
            @(negedge clk);
        end
        check_value("o_tx_interrupt width", cnt, 5);
        check_value("o_tx_status.state", o_tx_status.state, tlk_tx_pkg::TX_IDLE);
        check_value("o_tx_status.mode", o_tx_status.mode, tlk_tx_pkg::TX_MODE_NORM);
        check_value("o_tx_status.fifo_empty", o_tx_status.fifo_empty, 0);

        // one beat still holds two unread words
        @(posedge clk);
        accepted = 0;
        i_dma_rd_valid <= 1'b1;
        i_dma_rd_data  <= {$random(seed), $random(seed)};
        @(negedge clk);
        while (o_dma_rd_ready === 1'b1) begin
            accepted++;
            if (accepted > 2 * `TLK_FIFO_BEATS) begin
                $display("timeout: fifo never reported full");
                stop_with_failure();
            end
            @(posedge clk);
            i_dma_rd_data <= {$random(seed), $random(seed)};
            @(negedge clk);
        end
        check_value("o_tx_status.fifo_full", o_tx_status.fifo_full, 1);
        check_value("beats accepted until full", accepted, `TLK_FIFO_BEATS - 1);
        repeat (3) @(negedge clk);
        check_value("intr pulses", intr_pulses, 1);
        @(posedge clk);
        i_dma_rd_valid <= 1'b0;

        // k-code mode after a soft reset
        i_soft_reset <= 1'b1;
        repeat (2) @(posedge clk);
        i_soft_reset <= 1'b0;
        @(posedge clk);
        i_tx_mode  <= tlk_tx_pkg::TX_MODE_KCODE;
        i_tx_start <= 1'b1;
        @(posedge clk);
        i_tx_start <= 1'b0;
        count_commas(16, cnt);
        check_value("o_tx_status.mode", o_tx_status.mode, tlk_tx_pkg::TX_MODE_KCODE);
        for (int i = 0; i < 32; i++) begin
            check_line_word("k-code", 1'b1, 1'b1, SOF_WORD);
            sample_word();
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- tlk2711_tx.f
+incdir+hdl
hdl/tlk_tx_pkg.sv
hdl/tx_word_fifo.sv
hdl/tx_frame_fsm.sv
hdl/tx_line_stage.sv
hdl/tlk2711_tx.sv
tests/tlk2711_tx_tb.sv
